//--- dv/dino_scene_vectors.txt
# W frame address data_hex          bus write, applied in the vertical blanking before the frame
# P frame x y r g b                 pixel probe with expected color, sorted by frame, y, x
P 0 25 41 135 206 235
P 0 27 41 0 0 0
P 0 26 42 0 0 0
P 0 1100 80 135 206 235
P 0 1150 80 255 255 0
P 0 500 100 135 206 235
P 0 500 280 0 0 0
P 0 500 290 139 69 19
P 0 120 300 110 50 10
P 0 500 400 100 40 10
W 1 3 5
W 1 13 9
P 1 27 41 0 0 0
P 1 1150 80 255 255 0
P 1 500 100 135 206 235
W 2 10 107
W 2 11 3c8
W 2 12 196
P 2 27 41 10 10 40
P 2 1150 80 255 255 255
P 2 500 100 10 10 40
P 2 200 150 10 10 40
P 2 201 150 0 0 0
P 2 205 151 0 0 0
W 3 10 c
P 3 1150 80 255 255 255
P 3 201 150 10 10 40
P 3 205 151 10 10 40
P 4 1150 80 255 255 0
P 4 500 100 135 206 235

//--- tb.f
+incdir+src
src/dino_scene_pkg.sv
src/vga_timing.sv
src/day_night.sv
src/background_render.sv
src/score_overlay.sv
src/dino_scene.sv
dv/dino_scene_checker.sv
dv/dino_scene_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= dino_scene_tb
RTL_TOP   ?= dino_scene
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG); true
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/dino_scene_tb.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module dino_scene_tb import dino_scene_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [8:0]  address;
    logic [31:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_clk;

    int          wr_frame[$];
    logic [8:0]  wr_addr[$];
    logic [31:0] wr_data[$];
    int          pr_frame[$];
    int          pr_x[$];
    int          pr_y[$];
    rgb_t        pr_color[$];
    int          last_frame;
    bit          vectors_loaded;

    // Raster tracker state
    int frame_num;
    int x;
    int y;
    int pidx;
    int line_len;
    int hs_low;
    int blank_len;
    int vs_low;
    int active_lines;
    bit line_seen;
    bit prev_hs;
    bit prev_vs;
    bit prev_blank;

    dino_scene #(
        .DAY_FRAMES (2)
    ) dino_scene_inst (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_color(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            fail($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_interval(input string name, input int got, input int exp);
        if (got != exp) begin
            fail($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        int          f;
        int          a;
        int          px;
        int          py;
        int          r;
        int          g;
        int          b;
        logic [31:0] d;
        string       line;
        fd = $fopen("dv/dino_scene_vectors.txt", "r");
        if (fd == 0) begin
            fail("cannot open the vector file dv/dino_scene_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "W") begin
                n = $sscanf(line, "W %d %d %h", f, a, d);
                if (n != 3) begin
                    fail({"malformed write line in vector file: ", line});
                end
                wr_frame.push_back(f);
                wr_addr.push_back(9'(a));
                wr_data.push_back(d);
                if (f > last_frame) last_frame = f;
            end else if (line.len() > 0 && line[0] == "P") begin
                n = $sscanf(line, "P %d %d %d %d %d %d", f, px, py, r, g, b);
                if (n != 6) begin
                    fail({"malformed probe line in vector file: ", line});
                end
                pr_frame.push_back(f);
                pr_x.push_back(px);
                pr_y.push_back(py);
                pr_color.push_back('{r: 8'(r), g: 8'(g), b: 8'(b)});
                if (f > last_frame) last_frame = f;
            end
        end
        $fclose(fd);
    endtask

    // Follows the raster from the DUT pins, sampled away from the driving edge
    always @(negedge clk) begin
        if (!reset) begin
            if (prev_hs && !vga_hs) begin
                if (line_seen) check_interval("hs period", line_len, `H_TOTAL);
                line_seen = 1'b1;
                line_len  = 0;
            end
            line_len++;
            if (!prev_hs && vga_hs) begin
                check_interval("vga_hs low cycles", hs_low, `H_SYNC);
                hs_low = 0;
            end
            if (!vga_hs) hs_low++;

            if (vga_blank_n) begin
                if (!prev_blank) begin
                    x         = 0;
                    blank_len = 0;
                end else begin
                    x++;
                end
                blank_len++;
                // vga_clk is the low bit of the pixel column
                check_level("vga_clk", vga_clk, x[0]);
                if (pidx < pr_frame.size() && pr_frame[pidx] == frame_num &&
                    pr_y[pidx] == y && pr_x[pidx] == x) begin
                    check_color($sformatf("vga_rgb frame %0d x %0d y %0d", frame_num, x, y),
                                {vga_r, vga_g, vga_b}, pr_color[pidx]);
                    pidx++;
                end
            end else if (prev_blank) begin
                check_interval("vga_blank_n high cycles", blank_len, `H_ACTIVE);
                y++;
                active_lines++;
            end

            if (prev_vs && !vga_vs) begin
                check_interval("active lines per frame", active_lines, `V_ACTIVE);
                active_lines = 0;
                y            = 0;
                vs_low       = 0;
                frame_num++;
            end
            if (!prev_vs && vga_vs) begin
                check_interval("vga_vs low cycles", vs_low, `V_SYNC * `H_TOTAL);
            end
            if (!vga_vs) vs_low++;

            prev_hs    = vga_hs;
            prev_vs    = vga_vs;
            prev_blank = vga_blank_n;
        end
    end

    initial begin
        realtime limit_ns;
        wait (vectors_loaded);
        limit_ns = (last_frame + 2) * `H_TOTAL * `V_TOTAL * 10.0 * 1.5;
        #(limit_ns);
        fail("watchdog expired before the last vector frame completed");
    end

    initial begin
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        prev_hs    = 1'b1;
        prev_vs    = 1'b1;
        prev_blank = 1'b0;
        read_vectors();
        vectors_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < wr_frame.size(); i++) begin
            wait (frame_num >= wr_frame[i]);
            if (frame_num > wr_frame[i]) begin
                fail($sformatf("bus write for frame %0d came too late", wr_frame[i]));
            end
            @(posedge clk);
            #1;
            chipselect = 1'b1;
            write      = 1'b1;
            address    = wr_addr[i];
            writedata  = wr_data[i];
            @(posedge clk);
            #1;
            chipselect = 1'b0;
            write      = 1'b0;
        end

        wait (frame_num > last_frame);
        if (pidx != pr_frame.size()) begin
            fail($sformatf("probe %0d was never reached by the raster", pidx));
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- dv/dino_scene_checker.sv
`timescale 1ns/10ps

module dino_scene_checker (
    input logic       clk,
    input logic       reset,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b,
    input logic       vga_hs,
    input logic       vga_vs,
    input logic       vga_blank_n,
    input logic       vga_clk
);

    logic [8:0] hs_low_count;
    logic [1:0] settle;

    // Low cycles of hs, and pipeline fill after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_low_count <= '0;
            settle       <= '0;
        end else begin
            if (!vga_hs) begin
                hs_low_count <= hs_low_count + 1'b1;
            end else begin
                hs_low_count <= '0;
            end
            if (settle != 2'd3) begin
                settle <= settle + 1'b1;
            end
        end
    end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h0))
        else $error("color not black during blanking");

    hs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hs) |-> (hs_low_count == 9'd192))
        else $error("hs low width is not 192 cycles");

    clk_toggle: assert property (@(posedge clk) disable iff (reset || settle != 2'd3)
        vga_clk != $past(vga_clk))
        else $error("vga_clk did not toggle");

    // vs moves at a line start, which is always in blanking
    vs_in_blank: assert property (@(posedge clk) disable iff (reset)
        $changed(vga_vs) |-> !vga_blank_n)
        else $error("vs changed inside the active area");

endmodule

bind dino_scene dino_scene_checker dino_scene_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n),
    .vga_clk     (vga_clk)
);

//--- src/dino_scene.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module dino_scene import dino_scene_pkg::*; #(
    parameter int unsigned DAY_FRAMES = `DAY_FRAMES_DEFAULT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [8:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_clk
);

    raster_t  pix_raster;
    raster_t  stage_raster;
    raster_t  final_raster;
    palette_t palette;
    rgb_t     stage_color;
    rgb_t     final_color;

    vga_timing vga_timing_inst (
        .clk    (clk),
        .reset  (reset),
        .raster (pix_raster)
    );

    day_night #(
        .DAY_FRAMES (DAY_FRAMES)
    ) day_night_inst (
        .clk     (clk),
        .reset   (reset),
        .raster  (pix_raster),
        .palette (palette)
    );

    background_render background_render_inst (
        .clk        (clk),
        .reset      (reset),
        .raster_in  (pix_raster),
        .palette    (palette),
        .raster_out (stage_raster),
        .color      (stage_color)
    );

    score_overlay score_overlay_inst (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .raster_in  (stage_raster),
        .color_in   (stage_color),
        .raster_out (final_raster),
        .color_out  (final_color)
    );

    // Output pins
    assign vga_r       = final_color.r;
    assign vga_g       = final_color.g;
    assign vga_b       = final_color.b;
    assign vga_hs      = final_raster.hs;
    assign vga_vs      = final_raster.vs;
    assign vga_blank_n = final_raster.blank_n;
    assign vga_clk     = final_raster.vga_clk;

endmodule

//--- src/score_overlay.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module score_overlay import dino_scene_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [8:0]  address,
    input  logic [31:0] writedata,
    input  raster_t     raster_in,
    input  rgb_t        color_in,
    output raster_t     raster_out,
    output rgb_t        color_out
);

    logic [3:0]           score;
    logic [7:0]           score_x;
    logic [7:0]           score_y;
    logic                 in_box;
    logic [2:0]           glyph_row_idx;
    logic [2:0]           glyph_col;
    logic [7:0]           glyph_row;
    logic [63:0]          glyph;
    logic [`HCOUNT_W-1:0] box_dx;
    logic [`VCOUNT_W-1:0] box_dy;

    // 8x8 digit font, row 0 in the top byte; non-digits are blank
    function automatic logic [63:0] font(input logic [3:0] digit);
        case (digit)
            4'd0: font = 64'h3C666E7E76663C00;
            4'd1: font = 64'h1838181818187E00;
            4'd2: font = 64'h3C66061C30667E00;
            4'd3: font = 64'h3C66061C06663C00;
            4'd4: font = 64'h0C1C2C4C7E0C0C00;
            4'd5: font = 64'h7E607C0606663C00;
            4'd6: font = 64'h3C66607C66663C00;
            4'd7: font = 64'h7E060C1830303000;
            4'd8: font = 64'h3C66663C66663C00;
            4'd9: font = 64'h3C66663E06663C00;
            default: font = 64'h0;
        endcase
    endfunction

    // Bus writes, upper data bits dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score   <= 4'd0;
            score_x <= 8'd25;
            score_y <= 8'd41;
        end else if (chipselect && write) begin
            case (address)
                9'(`REG_SCORE):   score   <= writedata[3:0];
                9'(`REG_SCORE_X): score_x <= writedata[7:0];
                9'(`REG_SCORE_Y): score_y <= writedata[7:0];
                default: ;
            endcase
        end
    end

    // Offset inside the score box
    assign box_dx = raster_in.hcount - {3'b000, score_x};
    assign box_dy = raster_in.vcount - {2'b00, score_y};
    assign in_box = (raster_in.hcount >= {3'b000, score_x}) && (box_dx < `HCOUNT_W'(8)) &&
                    (raster_in.vcount >= {2'b00, score_y}) && (box_dy < `VCOUNT_W'(8));

    assign glyph_row_idx = box_dy[2:0];
    assign glyph_col     = box_dx[2:0];
    assign glyph         = font(score);
    assign glyph_row     = glyph[63 - 8 * glyph_row_idx -: 8];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster_out.hcount  <= '0;
            raster_out.vcount  <= '0;
            raster_out.hs      <= 1'b1;
            raster_out.vs      <= 1'b1;
            raster_out.blank_n <= 1'b0;
            raster_out.vga_clk <= 1'b0;
            color_out          <= '0;
        end else begin
            raster_out <= raster_in;
            // Leftmost box pixel is bit 7
            if (in_box && glyph_row[3'd7 - glyph_col]) begin
                color_out <= '0;
            end else begin
                color_out <= color_in;
            end
        end
    end

endmodule

//--- src/background_render.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module background_render import dino_scene_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  raster_t  raster_in,
    input  palette_t palette,
    output raster_t  raster_out,
    output rgb_t     color
);

    logic [`HCOUNT_W-1:0] hcount;
    logic [`VCOUNT_W-1:0] vcount;
    logic signed [11:0]   dx;
    logic signed [11:0]   dy;
    logic signed [24:0]   dist2;
    logic                 sun_hit;
    logic                 rock_rows;
    logic                 rock_hit;
    rgb_t                 scene;

    assign hcount = raster_in.hcount;
    assign vcount = raster_in.vcount;

    // Squared distance to the sun center
    assign dx      = $signed({1'b0, hcount}) - 12'sd`SUN_X;
    assign dy      = $signed({2'b00, vcount}) - 12'sd`SUN_Y;
    assign dist2   = dx * dx + dy * dy;
    assign sun_hit = (dist2 < 25'sd`SUN_R2);

    // Rocks only below the ground line
    assign rock_rows = (vcount > `VCOUNT_W'(`GROUND_ROW)) &&
                       (vcount < `VCOUNT_W'(`V_ACTIVE));
    assign rock_hit = rock_rows &&
        (((hcount % `ROCK_A_MOD) == 0 && (vcount % `ROCK_A_VMOD) < `ROCK_A_VLEN) ||
         ((hcount % `ROCK_B_MOD) == `ROCK_B_OFS &&
          (vcount % `ROCK_B_VMOD) < `ROCK_B_VLEN));

    // Layers in rising priority, black in blanking
    always_comb begin
        scene = '0;
        if (raster_in.blank_n) begin
            if (vcount < `VCOUNT_W'(`GROUND_ROW)) begin
                scene = palette.sky;
            end else if (vcount == `VCOUNT_W'(`GROUND_ROW)) begin
                scene = '0;
            end else if (vcount <= `VCOUNT_W'(`STRIPE_ROW)) begin
                scene = `LIGHT_GROUND;
            end else begin
                scene = `DARK_GROUND;
            end
            if (rock_hit) begin
                scene = `ROCK;
            end
            if (sun_hit) begin
                scene = palette.sun;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster_out.hcount  <= '0;
            raster_out.vcount  <= '0;
            raster_out.hs      <= 1'b1;
            raster_out.vs      <= 1'b1;
            raster_out.blank_n <= 1'b0;
            raster_out.vga_clk <= 1'b0;
            color              <= '0;
        end else begin
            raster_out <= raster_in;
            color      <= scene;
        end
    end

endmodule

//--- src/day_night.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module day_night import dino_scene_pkg::*; #(
    parameter int unsigned DAY_FRAMES = `DAY_FRAMES_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  raster_t  raster,
    output palette_t palette
);

    localparam int FRAME_W = $clog2(DAY_FRAMES + 1);

    logic [FRAME_W-1:0] frame_count;
    logic               night;
    logic               last_pixel;

    // Last position of the frame, always inside blanking
    assign last_pixel = (raster.hcount == `HCOUNT_W'(`H_TOTAL - 1)) &&
                        (raster.vcount == `VCOUNT_W'(`V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_count <= '0;
            night       <= 1'b0;
        end else if (last_pixel) begin
            if (frame_count == FRAME_W'(DAY_FRAMES - 1)) begin
                frame_count <= '0;
                night       <= ~night;
            end else begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    always_comb begin
        if (night) begin
            palette.sky = `NIGHT_SKY;
            palette.sun = `NIGHT_SUN;
        end else begin
            palette.sky = `DAY_SKY;
            palette.sun = `DAY_SUN;
        end
    end

endmodule

//--- src/vga_timing.sv
`timescale 1ns/10ps
`include "dino_scene_cfg.svh"

module vga_timing import dino_scene_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output raster_t raster
);

    logic [`HCOUNT_W-1:0] hcount;
    logic [`VCOUNT_W-1:0] vcount;
    logic                 line_end;
    logic                 frame_end;

    assign line_end  = (hcount == `HCOUNT_W'(`H_TOTAL - 1));
    assign frame_end = (vcount == `VCOUNT_W'(`V_TOTAL - 1));

    // Pixel counter within the line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Line counter, steps once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        // Syncs are active low
        raster.hs = !((hcount >= `HCOUNT_W'(`H_ACTIVE + `H_FRONT)) &&
                      (hcount < `HCOUNT_W'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
        raster.vs = !((vcount >= `VCOUNT_W'(`V_ACTIVE + `V_FRONT)) &&
                      (vcount < `VCOUNT_W'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
        raster.blank_n = (hcount < `HCOUNT_W'(`H_ACTIVE)) &&
                         (vcount < `VCOUNT_W'(`V_ACTIVE));
        // Pixel clock at half the system clock
        raster.vga_clk = hcount[0];
    end

endmodule

//--- src/dino_scene_pkg.sv
`include "dino_scene_cfg.svh"

package dino_scene_pkg;

    // One 24-bit pixel color
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Raster position with its sync and blank signals
    typedef struct packed {
        logic [`HCOUNT_W-1:0] hcount;
        logic [`VCOUNT_W-1:0] vcount;
        logic                 hs;
        logic                 vs;
        logic                 blank_n;
        logic                 vga_clk;
    } raster_t;

    // Time of day colors
    typedef struct packed {
        rgb_t sky;
        rgb_t sun;
    } palette_t;

endpackage

//--- src/dino_scene_cfg.svh
`ifndef DINO_SCENE_CFG_SVH
`define DINO_SCENE_CFG_SVH

// Raster geometry for 1280x480, in clock cycles and lines
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96
`define H_TOTAL 1600
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525
`define HCOUNT_W 11
`define VCOUNT_W 10

// Scene rows
`define GROUND_ROW 280
`define STRIPE_ROW 300

// Sun disk, radius squared
`define SUN_X 1150
`define SUN_Y 80
`define SUN_R2 1200

// Ground rock patterns
`define ROCK_A_MOD 120
`define ROCK_A_VMOD 50
`define ROCK_A_VLEN 10
`define ROCK_B_MOD 200
`define ROCK_B_OFS 15
`define ROCK_B_VMOD 60
`define ROCK_B_VLEN 8

// Colors as {r, g, b}
`define DAY_SKY {8'd135, 8'd206, 8'd235}
`define NIGHT_SKY {8'd10, 8'd10, 8'd40}
`define DAY_SUN {8'd255, 8'd255, 8'd0}
`define NIGHT_SUN {8'd255, 8'd255, 8'd255}
`define LIGHT_GROUND {8'd139, 8'd69, 8'd19}
`define DARK_GROUND {8'd100, 8'd40, 8'd10}
`define ROCK {8'd110, 8'd50, 8'd10}

`define DAY_FRAMES_DEFAULT 3600

// Register map
`define REG_SCORE 10
`define REG_SCORE_X 11
`define REG_SCORE_Y 12

`endif
